// ==== rtl/adc_frontend.sv ====
// raw adc words are offset binary with negative slope; one register stage, no calibration
module adc_frontend import rp_pkg::*; (
  input  logic             adc_clk,
  input  logic             rst_n_i,
  input  logic [ADC_W-1:0] adc_dat_a_i,  // raw channel a
  input  logic [ADC_W-1:0] adc_dat_b_i,  // raw channel b
  output sample_t          adc_a_o,      // two's complement
  output sample_t          adc_b_o
);

  sample_t adc_a_q;
  sample_t adc_b_q;

  //----------------------------------------------------------------------
  // conversion register
  always_ff @(posedge adc_clk) begin
    if (!rst_n_i) begin
      adc_a_q <= '0;
      adc_b_q <= '0;
    end else begin
      adc_a_q <= sample_t'(flip_code(adc_dat_a_i)); // msb kept, rest inverted
      adc_b_q <= sample_t'(flip_code(adc_dat_b_i));
    end
  end

  assign adc_a_o = adc_a_q;
  assign adc_b_o = adc_b_q;

endmodule

// ==== rtl/dac_mix.sv ====
// dc offsets stand in for the waveform generator; output is offset binary, one word per channel
module dac_mix import rp_pkg::*; (
  input  logic             adc_clk,
  input  logic             rst_n_i,
  sys_bus_if.slave         bus,
  input  sample_t          ctl_a_i,
  input  sample_t          ctl_b_i,
  output logic [ADC_W-1:0] dac_dat_a_o,
  output logic [ADC_W-1:0] dac_dat_b_o
);

  logic [REGION_LSB-1:0] reg_ofs;
  sample_t               dc_q [2];     // per-lane offset
  sample_t               ctl [2];
  logic signed [ADC_W:0] sum [2];      // one guard bit
  sample_t               mix_q [2];    // saturated sum
  logic [ADC_W-1:0]      dac_q [2];    // encoded pin word

  assign reg_ofs = bus.addr[REGION_LSB-1:0];
  assign ctl[0]  = ctl_a_i;
  assign ctl[1]  = ctl_b_i;

  //----------------------------------------------------------------------
  // offset registers
  always_ff @(posedge adc_clk) begin
    if (!rst_n_i) begin
      bus.ack <= 1'b0;
      dc_q    <= '{default: '0};
    end else begin
      bus.ack <= bus.wen | bus.ren;
      if (bus.wen && (reg_ofs == OFS_DC_A))
        dc_q[0] <= bus.wdata[ADC_W-1:0];
      if (bus.wen && (reg_ofs == OFS_DC_B))
        dc_q[1] <= bus.wdata[ADC_W-1:0];
    end
  end

  assign bus.err = 1'b0;

  always_ff @(posedge adc_clk) begin
    if (bus.ren) begin
      case (reg_ofs)
        OFS_DC_A: bus.rdata <= BUS_DW'(dc_q[0]); // sign extended
        OFS_DC_B: bus.rdata <= BUS_DW'(dc_q[1]);
        default:  bus.rdata <= '0;
      endcase
    end
  end

  //----------------------------------------------------------------------
  // add, saturate, encode
  always_comb begin
    for (int i = 0; i < 2; i++)
      sum[i] = ctl[i] + dc_q[i];
  end

  always_ff @(posedge adc_clk) begin
    if (!rst_n_i) begin
      mix_q <= '{default: '0};
      dac_q <= '{default: flip_code('0)};        // encoding of zero
    end else begin
      for (int i = 0; i < 2; i++) begin
        case (sum[i][ADC_W -: 2])
          2'b01:   mix_q[i] <= {1'b0, {(ADC_W-1){1'b1}}}; // pos overflow, +8191
          2'b10:   mix_q[i] <= {1'b1, {(ADC_W-1){1'b0}}}; // neg overflow, -8192
          default: mix_q[i] <= sum[i][ADC_W-1:0];
        endcase
        dac_q[i] <= flip_code(mix_q[i]);         // back to dac format
      end
    end
  end

  assign dac_dat_a_o = dac_q[0];
  assign dac_dat_b_o = dac_q[1];

endmodule

// ==== rtl/housekeeping_regs.sv ====
// LED_W up to 32; adc snapshots are the live samples at the read strobe, not a held capture
module housekeeping_regs import rp_pkg::*; #(
  parameter int LED_W = 8
) (
  input  logic             adc_clk,
  input  logic             rst_n_i,
  sys_bus_if.slave         bus,
  input  sample_t          adc_a_i,
  input  sample_t          adc_b_i,
  output logic [LED_W-1:0] led_o
);

  logic [REGION_LSB-1:0] reg_ofs; // offset inside region 0
  logic                  ro_hit;  // id or sample register

  assign reg_ofs = bus.addr[REGION_LSB-1:0];
  assign ro_hit  = reg_ofs inside {OFS_ID, OFS_ADC_A, OFS_ADC_B};

  //----------------------------------------------------------------------
  // handshake and led register
  always_ff @(posedge adc_clk) begin
    if (!rst_n_i) begin
      bus.ack <= 1'b0;
      bus.err <= 1'b0;
      led_o   <= '0;
    end else begin
      bus.ack <= bus.wen | bus.ren;        // always one cycle
      bus.err <= bus.wen && ro_hit;        // writing read-only space
      if (bus.wen && (reg_ofs == OFS_LED))
        led_o <= bus.wdata[LED_W-1:0];
    end
  end

  // read data, sampled on the strobe
  always_ff @(posedge adc_clk) begin
    if (bus.ren) begin
      case (reg_ofs)
        OFS_ID:    bus.rdata <= HK_ID;
        OFS_LED:   bus.rdata <= BUS_DW'(led_o);   // zero extended
        OFS_ADC_A: bus.rdata <= BUS_DW'(adc_a_i); // sign extended
        OFS_ADC_B: bus.rdata <= BUS_DW'(adc_b_i);
        default:   bus.rdata <= '0;               // hole reads 0
      endcase
    end
  end

endmodule

// ==== rtl/p_controller.sv ====
// proportional only, no integrator; KP_SHIFT 0..12 keeps the product inside its 27 bits
module p_controller import rp_pkg::*; #(
  parameter int KP_SHIFT = 8
) (
  input  logic     adc_clk,
  input  logic     rst_n_i,
  sys_bus_if.slave bus,
  input  sample_t  adc_a_i,
  input  sample_t  adc_b_i,
  output sample_t  ctl_a_o,
  output sample_t  ctl_b_o
);

  localparam int PW = ADC_W + KP_W + 1;                          // product width
  localparam logic signed [PW-1:0] SAT_MAX = 2**(ADC_W-1) - 1;   // +8191
  localparam logic signed [PW-1:0] SAT_MIN = -(2**(ADC_W-1));    // -8192

  logic [REGION_LSB-1:0]    reg_ofs;
  sample_t                  sp [2];       // setpoints
  logic signed [KP_W-1:0]   kp [2];       // gains
  sample_t                  smp [2];      // lane inputs
  logic signed [ADC_W:0]    diff_q [2];   // stage 1, one bit of growth
  logic signed [PW-1:0]     prod [2];
  logic signed [PW-1:0]     shifted [2];
  sample_t                  ctl_q [2];    // stage 2

  assign reg_ofs = bus.addr[REGION_LSB-1:0];
  assign smp[0]  = adc_a_i;
  assign smp[1]  = adc_b_i;

  //----------------------------------------------------------------------
  // registers, lane a at 0x00/0x04, lane b at 0x08/0x0C
  always_ff @(posedge adc_clk) begin
    if (!rst_n_i) begin
      bus.ack <= 1'b0;
      sp      <= '{default: '0};
      kp      <= '{default: '0};
    end else begin
      bus.ack <= bus.wen | bus.ren;
      if (bus.wen) begin
        case (reg_ofs)
          OFS_SP_A: sp[0] <= bus.wdata[ADC_W-1:0];
          OFS_KP_A: kp[0] <= bus.wdata[KP_W-1:0];
          OFS_SP_B: sp[1] <= bus.wdata[ADC_W-1:0];
          OFS_KP_B: kp[1] <= bus.wdata[KP_W-1:0];
          default:  ;                              // holes ignore writes
        endcase
      end
    end
  end

  assign bus.err = 1'b0;                           // everything here is writable

  always_ff @(posedge adc_clk) begin
    if (bus.ren) begin
      case (reg_ofs)
        OFS_SP_A: bus.rdata <= BUS_DW'(sp[0]);     // sign extended
        OFS_KP_A: bus.rdata <= BUS_DW'(kp[0]);
        OFS_SP_B: bus.rdata <= BUS_DW'(sp[1]);
        OFS_KP_B: bus.rdata <= BUS_DW'(kp[1]);
        default:  bus.rdata <= '0;
      endcase
    end
  end

  //----------------------------------------------------------------------
  // data path, two stages per lane
  always_comb begin
    for (int i = 0; i < 2; i++) begin
      prod[i]    = diff_q[i] * kp[i];              // signed 15 x 12
      shifted[i] = prod[i] >>> KP_SHIFT;           // arithmetic scale down
    end
  end

  always_ff @(posedge adc_clk) begin
    if (!rst_n_i) begin
      diff_q <= '{default: '0};
      ctl_q  <= '{default: '0};
    end else begin
      for (int i = 0; i < 2; i++) begin
        diff_q[i] <= sp[i] - smp[i];               // error = setpoint - sample
        if (shifted[i] > SAT_MAX)
          ctl_q[i] <= sample_t'(SAT_MAX);          // clip high
        else if (shifted[i] < SAT_MIN)
          ctl_q[i] <= sample_t'(SAT_MIN);          // clip low
        else
          ctl_q[i] <= shifted[i][ADC_W-1:0];
      end
    end
  end

  assign ctl_a_o = ctl_q[0];
  assign ctl_b_o = ctl_q[1];

endmodule

// ==== rtl/rp_pkg.sv ====
// 14-bit converter and 32-bit system bus only; register offsets are byte addresses inside a 1 MB region
package rp_pkg;

  //----------------------------------------------------------------------
  // data path widths
  localparam int ADC_W = 14;                          // adc and dac pin width
  localparam int KP_W  = 12;                          // gain width

  typedef logic signed [ADC_W-1:0] sample_t;         // two's complement sample

  //----------------------------------------------------------------------
  // system bus
  localparam int BUS_AW      = 32;
  localparam int BUS_DW      = 32;
  localparam int NUM_REGIONS = 8;
  localparam int REGION_LSB  = 20;                    // region field is addr[22:20]
  localparam int REGION_W    = $clog2(NUM_REGIONS);

  localparam int REG_HK   = 0;                        // housekeeping
  localparam int REG_OFS  = 2;                        // dc offsets, in place of the generator
  localparam int REG_PCTL = 3;                        // proportional controller

  // region 0
  localparam logic [REGION_LSB-1:0] OFS_ID    = 'h00; // read only
  localparam logic [REGION_LSB-1:0] OFS_LED   = 'h04;
  localparam logic [REGION_LSB-1:0] OFS_ADC_A = 'h08; // read only, sign extended
  localparam logic [REGION_LSB-1:0] OFS_ADC_B = 'h0C; // read only, sign extended
  // region 2
  localparam logic [REGION_LSB-1:0] OFS_DC_A  = 'h00;
  localparam logic [REGION_LSB-1:0] OFS_DC_B  = 'h04;
  // region 3
  localparam logic [REGION_LSB-1:0] OFS_SP_A  = 'h00;
  localparam logic [REGION_LSB-1:0] OFS_KP_A  = 'h04;
  localparam logic [REGION_LSB-1:0] OFS_SP_B  = 'h08;
  localparam logic [REGION_LSB-1:0] OFS_KP_B  = 'h0C;

  localparam logic [BUS_DW-1:0] HK_ID = 32'h5250_0A01; // design id

  // offset binary with negative slope <-> two's complement, same rule both ways
  function automatic logic [ADC_W-1:0] flip_code(input logic [ADC_W-1:0] x);
    return {x[ADC_W-1], ~x[ADC_W-2:0]};               // keep msb, invert the rest
  endfunction

endpackage

// ==== rtl/rp_top.sv ====
// analog core only: single adc_clk domain, no processor, scope, generator memory or pwm dacs
module rp_top import rp_pkg::*; #(
  parameter int KP_SHIFT = 8,                // controller gain scaling, 0..12
  parameter int LED_W    = 8
) (
  input  logic              adc_clk,
  input  logic              rst_n_i,
  input  logic [ADC_W-1:0]  adc_dat_a_i,      // raw adc channel a
  input  logic [ADC_W-1:0]  adc_dat_b_i,      // raw adc channel b
  input  logic [BUS_AW-1:0] sys_addr_i,
  input  logic [BUS_DW-1:0] sys_wdata_i,
  input  logic              sys_wen_i,
  input  logic              sys_ren_i,
  output logic [BUS_DW-1:0] sys_rdata_o,
  output logic              sys_ack_o,
  output logic              sys_err_o,
  output logic [ADC_W-1:0]  dac_dat_a_o,      // dac channel a
  output logic [ADC_W-1:0]  dac_dat_b_o,      // dac channel b
  output logic [LED_W-1:0]  led_o
);

  sys_bus_if hk_bus ();                       // region 0
  sys_bus_if ofs_bus ();                      // region 2
  sys_bus_if pctl_bus ();                     // region 3

  sample_t adc_a, adc_b;                      // converted samples
  sample_t ctl_a, ctl_b;                      // controller outputs

  //----------------------------------------------------------------------
  // bus
  sys_bus_decoder i_dec (
    .adc_clk, .rst_n_i, .sys_addr_i, .sys_wdata_i, .sys_wen_i, .sys_ren_i,
    .sys_rdata_o, .sys_ack_o, .sys_err_o,
    .hk_bus(hk_bus), .ofs_bus(ofs_bus), .pctl_bus(pctl_bus)
  );

  housekeeping_regs #(.LED_W(LED_W)) i_hk (
    .adc_clk, .rst_n_i, .bus(hk_bus), .adc_a_i(adc_a), .adc_b_i(adc_b), .led_o
  );

  //----------------------------------------------------------------------
  // data path, 5 cycles pin to pin
  adc_frontend i_adc (
    .adc_clk, .rst_n_i, .adc_dat_a_i, .adc_dat_b_i, .adc_a_o(adc_a), .adc_b_o(adc_b)
  );

  p_controller #(.KP_SHIFT(KP_SHIFT)) i_pctl (
    .adc_clk, .rst_n_i, .bus(pctl_bus), .adc_a_i(adc_a), .adc_b_i(adc_b),
    .ctl_a_o(ctl_a), .ctl_b_o(ctl_b)
  );

  dac_mix i_mix (
    .adc_clk, .rst_n_i, .bus(ofs_bus), .ctl_a_i(ctl_a), .ctl_b_i(ctl_b),
    .dac_dat_a_o, .dac_dat_b_o
  );

endmodule

// ==== rtl/sys_bus_decoder.sv ====
// regions 1 and 4..7 are answered here with rdata 0; one access in flight at a time
module sys_bus_decoder import rp_pkg::*; (
  input  logic              adc_clk,
  input  logic              rst_n_i,
  input  logic [BUS_AW-1:0] sys_addr_i,
  input  logic [BUS_DW-1:0] sys_wdata_i,
  input  logic              sys_wen_i,
  input  logic              sys_ren_i,
  output logic [BUS_DW-1:0] sys_rdata_o,
  output logic              sys_ack_o,
  output logic              sys_err_o,
  sys_bus_if.master         hk_bus,
  sys_bus_if.master         ofs_bus,
  sys_bus_if.master         pctl_bus
);

  logic [REGION_W-1:0] region;     // from the live address
  logic [REGION_W-1:0] region_q;   // region of the access in flight
  logic                strobe;
  logic                unused;     // no slave behind this region
  logic                unused_ack; // local answer, one cycle late

  assign region = sys_addr_i[REGION_LSB +: REGION_W];
  assign strobe = sys_wen_i | sys_ren_i;
  assign unused = !(region inside {REG_HK, REG_OFS, REG_PCTL});

  //----------------------------------------------------------------------
  // address and data go to everyone, strobes only to the selected slave
  assign hk_bus.addr    = sys_addr_i;
  assign hk_bus.wdata   = sys_wdata_i;
  assign hk_bus.wen     = sys_wen_i && (region == REG_HK);
  assign hk_bus.ren     = sys_ren_i && (region == REG_HK);
  assign ofs_bus.addr   = sys_addr_i;
  assign ofs_bus.wdata  = sys_wdata_i;
  assign ofs_bus.wen    = sys_wen_i && (region == REG_OFS);
  assign ofs_bus.ren    = sys_ren_i && (region == REG_OFS);
  assign pctl_bus.addr  = sys_addr_i;
  assign pctl_bus.wdata = sys_wdata_i;
  assign pctl_bus.wen   = sys_wen_i && (region == REG_PCTL);
  assign pctl_bus.ren   = sys_ren_i && (region == REG_PCTL);

  always_ff @(posedge adc_clk) begin
    if (!rst_n_i) begin
      region_q   <= '0;
      unused_ack <= 1'b0;
    end else begin
      unused_ack <= strobe && unused;      // pending flag for empty regions
      if (strobe)
        region_q <= region;                // remembered for the return mux
    end
  end

  //----------------------------------------------------------------------
  // return path
  always_comb begin
    sys_rdata_o = '0;                      // empty regions read 0
    case (region_q)
      REG_HK:   sys_rdata_o = hk_bus.rdata;
      REG_OFS:  sys_rdata_o = ofs_bus.rdata;
      REG_PCTL: sys_rdata_o = pctl_bus.rdata;
      default:  sys_rdata_o = '0;
    endcase
  end

  // only the strobed slave can ack, so a plain or is enough
  assign sys_ack_o = hk_bus.ack | ofs_bus.ack | pctl_bus.ack | unused_ack;
  assign sys_err_o = hk_bus.err | ofs_bus.err | pctl_bus.err;

endmodule

// ==== rtl/sys_bus_if.sv ====
// single outstanding access only: master holds addr and wdata until ack, no back-pressure
interface sys_bus_if import rp_pkg::*; ();

  logic [BUS_AW-1:0] addr;   // byte address
  logic [BUS_DW-1:0] wdata;  // write data
  logic              wen;    // one-cycle write strobe
  logic              ren;    // one-cycle read strobe
  logic [BUS_DW-1:0] rdata;  // valid with ack
  logic              ack;    // one cycle after the strobe
  logic              err;    // only together with ack

  modport master (
    output addr, wdata, wen, ren,
    input  rdata, ack, err
  );

  modport slave (
    input  addr, wdata, wen, ren,
    output rdata, ack, err
  );

endinterface

// ==== sources.f ====
rtl/rp_pkg.sv
rtl/sys_bus_if.sv
rtl/sys_bus_decoder.sv
rtl/adc_frontend.sv
rtl/housekeeping_regs.sv
rtl/p_controller.sv
rtl/dac_mix.sv
rtl/rp_top.sv
test/tb_asserts.sv
test/tb_checker.sv
test/tb_top.sv

// ==== test/tb_asserts.sv ====
// bus protocol rules at the rp_top ports; checked only while rst_n_i is high
module tb_asserts import rp_pkg::*; (
  input logic adc_clk,
  input logic rst_n_i,
  input logic wen_i,
  input logic ren_i,
  input logic ack_i,
  input logic err_i
);

  int unsigned fails = 0;                 // read by tb_top for the summary

  //----------------------------------------------------------------------
  // handshake
  ack_one_cycle: assert property (@(posedge adc_clk) disable iff (!rst_n_i)
    ack_i |=> !ack_i)
    else begin
      fails++;
      $error("ack high for two cycles in a row");
    end

  ack_after_strobe: assert property (@(posedge adc_clk) disable iff (!rst_n_i)
    (wen_i || ren_i) |=> ack_i)
    else begin
      fails++;
      $error("no ack one cycle after the strobe");
    end

  ack_needs_strobe: assert property (@(posedge adc_clk) disable iff (!rst_n_i)
    ack_i |-> $past(wen_i || ren_i))
    else begin
      fails++;
      $error("ack without a strobe one cycle before");
    end

  err_with_ack: assert property (@(posedge adc_clk) disable iff (!rst_n_i)
    err_i |-> ack_i)
    else begin
      fails++;
      $error("err raised without ack");
    end

endmodule

// ==== test/tb_checker.sv ====
// samples the DUT at the falling edge, half a cycle away from every register update
module tb_checker import rp_pkg::*; #(
  parameter int LED_W = 8
) (
  input logic              adc_clk,
  input logic              wen_i,
  input logic              ren_i,
  input logic [BUS_DW-1:0] rdata_i,
  input logic              ack_i,
  input logic              err_i,
  input logic [ADC_W-1:0]  dac_a_i,
  input logic [ADC_W-1:0]  dac_b_i,
  input logic [LED_W-1:0]  led_i
);

  int unsigned       tests       = 0;    // finished tests
  int unsigned       failed      = 0;
  int                cur_test    = 0;
  logic              bus_done    = 1'b1; // polled by tb_top
  logic              strobe_seen = 1'b0; // strobe at the last falling edge
  logic              test_bad    = 1'b0;
  logic              exp_read    = 1'b0;
  logic [BUS_DW-1:0] exp_rdata   = '0;
  logic              exp_err     = 1'b0;

  //----------------------------------------------------------------------
  // helpers
  task automatic compare_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
    if (act !== exp) begin
      $display("error at %0t: %s expected %h, got %h (test %0d)",
               $time, name, exp, act, cur_test);
      test_bad = 1'b1;
    end
  endtask

  task automatic close_test();
    tests++;
    if (test_bad)
      failed++;
    else
      $display("test %0d passed at %0t", cur_test, $time);
  endtask

  // armed before the strobe, checked in the ack cycle
  task automatic expect_bus(input int n, input bit is_read,
                            input logic [BUS_DW-1:0] rdata, input bit err);
    cur_test  = n;
    exp_read  = is_read;
    exp_rdata = rdata;
    exp_err   = err;
    bus_done  = 1'b0;
  endtask

  task automatic check_dac(input int n, input logic [ADC_W-1:0] exp_a,
                           input logic [ADC_W-1:0] exp_b);
    @(negedge adc_clk);
    cur_test = n;
    test_bad = 1'b0;
    compare_value("dac_dat_a_o", 32'(exp_a), 32'(dac_a_i));
    compare_value("dac_dat_b_o", 32'(exp_b), 32'(dac_b_i));
    close_test();
  endtask

  task automatic check_led(input int n, input logic [31:0] exp);
    @(negedge adc_clk);
    cur_test = n;
    test_bad = 1'b0;
    compare_value("led_o", exp, 32'(led_i));
    close_test();
  endtask

  //----------------------------------------------------------------------
  // bus watcher, ack due one cycle after the strobe
  always @(negedge adc_clk) begin
    if (strobe_seen) begin
      test_bad = 1'b0;
      if (ack_i !== 1'b1) begin
        $display("test %0d: no ack in the cycle after the strobe, at %0t", cur_test, $time);
        test_bad = 1'b1;
      end else begin
        compare_value("sys_err_o", 32'(exp_err), 32'(err_i));
        if (exp_read)
          compare_value("sys_rdata_o", exp_rdata, rdata_i); // only reads return data
      end
      close_test();
      bus_done = 1'b1;
    end
    strobe_seen = wen_i | ren_i;
  end

endmodule

// ==== test/tb_top.sv ====
// run from the project root; one test per data line, inputs change 2 units after the rising edge
module tb_top import rp_pkg::*; ();

  localparam int CLK_PERIOD      = 40;
  localparam int RST_CYCLES      = 10;
  localparam int CYCLES_PER_TEST = 20;  // watchdog budget per line
  localparam int LED_W           = 8;

  logic              adc_clk;
  logic              rst_n;
  logic [ADC_W-1:0]  adc_dat_a, adc_dat_b;    // raw adc words
  logic [BUS_AW-1:0] sys_addr;
  logic [BUS_DW-1:0] sys_wdata, sys_rdata;
  logic              sys_wen, sys_ren, sys_ack, sys_err;
  logic [ADC_W-1:0]  dac_dat_a, dac_dat_b;
  logic [LED_W-1:0]  led;

  string       cmd_q[$];                      // one entry per data line
  logic [31:0] op1_q[$], op2_q[$], exp1_q[$], exp2_q[$];
  int          n_tests     = 0;
  int          other_fails = 0;               // failures outside the checker
  bit          load_ok     = 1'b0;

  rp_top #(.KP_SHIFT(8), .LED_W(LED_W)) DUT (
    .adc_clk(adc_clk), .rst_n_i(rst_n), .adc_dat_a_i(adc_dat_a), .adc_dat_b_i(adc_dat_b),
    .sys_addr_i(sys_addr), .sys_wdata_i(sys_wdata), .sys_wen_i(sys_wen), .sys_ren_i(sys_ren),
    .sys_rdata_o(sys_rdata), .sys_ack_o(sys_ack), .sys_err_o(sys_err),
    .dac_dat_a_o(dac_dat_a), .dac_dat_b_o(dac_dat_b), .led_o(led)
  );

  tb_checker #(.LED_W(LED_W)) u_chk (
    .adc_clk(adc_clk), .wen_i(sys_wen), .ren_i(sys_ren), .rdata_i(sys_rdata),
    .ack_i(sys_ack), .err_i(sys_err), .dac_a_i(dac_dat_a), .dac_b_i(dac_dat_b), .led_i(led)
  );

  bind rp_top tb_asserts u_asserts (
    .adc_clk(adc_clk), .rst_n_i(rst_n_i), .wen_i(sys_wen_i), .ren_i(sys_ren_i),
    .ack_i(sys_ack_o), .err_i(sys_err_o)
  );

  //----------------------------------------------------------------------
  // clock, reset, watchdog
  initial begin
    adc_clk = 1'b0;
    forever #(CLK_PERIOD/2) adc_clk = ~adc_clk;
  end

  initial begin
    rst_n = 1'b0;
    repeat (RST_CYCLES) @(posedge adc_clk);
    #2;
    rst_n = 1'b1;
  end

  initial begin : watchdog
    wait (n_tests > 0);                       // budget known once the file is read
    #((RST_CYCLES + n_tests * CYCLES_PER_TEST) * CLK_PERIOD);
    $display("timeout: tests did not finish within %0d cycles",
             RST_CYCLES + n_tests * CYCLES_PER_TEST);
    $display("Simulation failed");
    $finish;
  end

  //----------------------------------------------------------------------
  // stimulus
  task automatic bus_access(input int n, input bit is_read, input logic [BUS_AW-1:0] addr,
                            input logic [BUS_DW-1:0] wdata,
                            input logic [BUS_DW-1:0] exp_rdata, input bit exp_err);
    int waited;
    u_chk.expect_bus(n, is_read, exp_rdata, exp_err);
    @(posedge adc_clk);
    #2;
    sys_addr  = addr;                         // held until the next access
    sys_wdata = wdata;
    sys_wen   = !is_read;
    sys_ren   = is_read;
    @(posedge adc_clk);
    #2;
    sys_wen = 1'b0;                           // one-cycle strobe
    sys_ren = 1'b0;
    waited  = 0;
    while (!u_chk.bus_done && waited < 8) begin
      @(posedge adc_clk);
      waited++;
    end
    if (!u_chk.bus_done) begin
      $display("test %0d: bus access never completed", n);
      other_fails++;
    end
  endtask

  task automatic sample_test(input int n, input logic [31:0] raw_a, input logic [31:0] raw_b,
                             input logic [31:0] exp_a, input logic [31:0] exp_b);
    @(posedge adc_clk);
    #2;
    adc_dat_a = raw_a[ADC_W-1:0];
    adc_dat_b = raw_b[ADC_W-1:0];
    repeat (5) @(posedge adc_clk);            // pin to pin latency
    u_chk.check_dac(n, exp_a[ADC_W-1:0], exp_b[ADC_W-1:0]);
  endtask

  initial begin : run
    int          fd;
    int          rc;
    string       line;
    string       cmd;
    logic [31:0] f1, f2, f3, f4;
    adc_dat_a = 14'h1fff;                     // sample 0
    adc_dat_b = 14'h1fff;
    sys_addr  = '0;
    sys_wdata = '0;
    sys_wen   = 1'b0;
    sys_ren   = 1'b0;
    fd = $fopen("test/testdata.txt", "r");
    if (fd == 0) begin
      $display("cannot open test/testdata.txt");
    end else begin
      load_ok = 1'b1;
      while (!$feof(fd)) begin
        line = "";
        rc   = $fgets(line, fd);
        if (rc == 0 || line.len() < 2 || line[0] == "#")
          continue;                           // end of file, blank or column notes
        if ($sscanf(line, "%s %h %h %h %h", cmd, f1, f2, f3, f4) == 5) begin
          cmd_q.push_back(cmd);
          op1_q.push_back(f1);
          op2_q.push_back(f2);
          exp1_q.push_back(f3);
          exp2_q.push_back(f4);
        end
      end
      $fclose(fd);
      n_tests = cmd_q.size();
    end
    wait (rst_n === 1'b1);
    for (int i = 0; i < n_tests; i++) begin
      case (cmd_q[i])
        "W": bus_access(i + 1, 1'b0, op1_q[i], op2_q[i], '0, exp1_q[i][0]);
        "R": bus_access(i + 1, 1'b1, op1_q[i], '0, exp1_q[i], exp2_q[i][0]);
        "S": sample_test(i + 1, op1_q[i], op2_q[i], exp1_q[i], exp2_q[i]);
        "L": u_chk.check_led(i + 1, exp1_q[i]);
        default: begin
          $display("test %0d: unknown command %s", i + 1, cmd_q[i]);
          other_fails++;
        end
      endcase
    end
    repeat (2) @(posedge adc_clk);
    $display("tests: %0d, failed: %0d, assertion failures: %0d, other failures: %0d",
             u_chk.tests, u_chk.failed, DUT.u_asserts.fails, other_fails);
    if (!load_ok || n_tests == 0 || u_chk.failed != 0 || other_fails != 0 ||
        DUT.u_asserts.fails != 0) begin
      $display("Simulation failed");
    end else begin
      $display("Simulation passed");
    end
    $finish;
  end

endmodule

// ==== test/testdata.txt ====
# cmd op1 op2 exp1 exp2, hex: W addr wdata err 0 | R addr 0 rdata err
# S raw_a raw_b dac_a dac_b | L 0 0 led 0
S 00001fff 00001fff 00001fff 00001fff
L 00000000 00000000 00000000 00000000
R 00000000 00000000 52500a01 00000000
W 00000004 000000a5 00000000 00000000
R 00000004 00000000 000000a5 00000000
L 00000000 00000000 000000a5 00000000
W 00000000 12345678 00000001 00000000
W 00000008 00000001 00000001 00000000
W 0000000c 00000001 00000001 00000000
R 00000000 00000000 52500a01 00000000
R 00000010 00000000 00000000 00000000
W 00000014 ffffffff 00000000 00000000
R 00100000 00000000 00000000 00000000
W 00500008 deadbeef 00000000 00000000
R 00700004 00000000 00000000 00000000
S 00000000 00003fff 00001fff 00001fff
R 00000008 00000000 00001fff 00000000
R 0000000c 00000000 ffffe000 00000000
S 00001234 00002abc 00001fff 00001fff
R 00000008 00000000 00000dcb 00000000
R 0000000c 00000000 fffff543 00000000
W 00200000 00000123 00000000 00000000
W 00200004 00003f00 00000000 00000000
R 00200000 00000000 00000123 00000000
R 00200004 00000000 ffffff00 00000000
R 00200008 00000000 00000000 00000000
S 00001fff 00001fff 00001edc 000020ff
W 00300000 00000100 00000000 00000000
W 00300004 00000010 00000000 00000000
W 00300008 00003000 00000000 00000000
W 0030000c 00000ff0 00000000 00000000
R 00300000 00000000 00000100 00000000
R 00300004 00000000 00000010 00000000
R 00300008 00000000 fffff000 00000000
R 0030000c 00000000 fffffff0 00000000
S 00002063 00001f9b 00001ec6 00001ff9
S 00001e0b 00001f9b 00001eec 00001ff9
W 00300000 00001fff 00000000 00000000
W 00300004 000007ff 00000000 00000000
W 0030000c 000007ff 00000000 00000000
S 00003fff 00000000 00000000 00003fff
W 00300000 00001000 00000000 00000000
W 00300004 00000100 00000000 00000000
W 0030000c 00000100 00000000 00000000
W 00200000 00001000 00000000 00000000
W 00200004 00002fff 00000000 00000000
S 00001fff 00001fff 00000000 00003fff
